// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f list.f --top-module tb_display_mode -o tb_display_mode
	./obj_dir/tb_display_mode | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/clock_prog_pkg.sv ====
package clock_prog_pkg;
	import video_mode_pkg::*;

	// M or D, goes out on the wire as value minus one
	typedef logic [7:0] synth_val_t;

	typedef struct packed {
		synth_val_t m;
		synth_val_t d;
	} synth_pair_t;

	// Command header, bit 0 is shifted out first
	typedef enum logic [1:0] {
		LOAD_D = 2'b01, // 1 then 0
		LOAD_M = 2'b11  // 1 then 1
	} prog_cmd_t;

	typedef enum logic [2:0] {
		PS_IDLE,
		PS_START,  // Idle cycle ahead of the D frame
		PS_LOAD_D,
		PS_GAP_D,
		PS_LOAD_M,
		PS_GAP_M,
		PS_GO,
		PS_WAIT    // Waiting for the done flag
	} prog_state_t;

	// Pixel clock = 50 MHz * M / D
	function automatic synth_pair_t clock_lookup(video_mode_t mode);
		case (mode)
			MODE_VGA:    return '{8'd2,   8'd4};   // 25 MHz
			MODE_SVGA:   return '{8'd4,   8'd5};   // 40 MHz
			MODE_XGA:    return '{8'd13,  8'd10};  // 65 MHz
			MODE_SXGA:   return '{8'd54,  8'd25};  // 108 MHz
			MODE_CAMERA: return '{8'd135, 8'd91};  // Just under 74.25 MHz
			default:     return '{8'd248, 8'd167}; // 74.25 MHz
		endcase
	endfunction

endpackage

// ==== design/display_mode_top.sv ====
`timescale 1ns/10ps

module display_mode_top #(
	parameter int DEBOUNCE_CYCLES = 65536  // Switch settle time in clocks
) (
	input  logic                       clk50m_bufg,
	input  logic                       RSTBTN,
	input  video_mode_pkg::mode_code_t sw,
	input  logic                       progdone,
	output logic                       progen,
	output logic                       progdata,
	output logic                       busy,
	output logic                       hsync,
	output logic                       vsync,
	output logic                       de,
	output video_mode_pkg::tcount_t    hcount,
	output video_mode_pkg::tcount_t    vcount
);
	import video_mode_pkg::*;

	video_mode_t mode;         // Current display mode
	logic        mode_change;  // One cycle, starts programming and restarts timing

	////////////////////////////////////////////////////////////////////////////
	// Mode switches
	////////////////////////////////////////////////////////////////////////////

	mode_select #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) i_mode_select (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.mode        (mode),
		.mode_change (mode_change)
	);

	// Serial M/D load into the pixel clock synthesizer
	pclk_programmer i_pclk_programmer (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.mode        (mode),
		.mode_change (mode_change),
		.progdone    (progdone),
		.progen      (progen),
		.progdata    (progdata),
		.busy        (busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// Video timing
	////////////////////////////////////////////////////////////////////////////

	video_timing i_video_timing (
		.clk50m_bufg (clk50m_bufg),  // Stands in for the pixel clock
		.RSTBTN      (RSTBTN),
		.mode        (mode),
		.mode_change (mode_change),
		.hcount      (hcount),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

endmodule

// ==== design/mode_select.sv ====
`timescale 1ns/10ps

module mode_select #(
	parameter int DEBOUNCE_CYCLES = 65536
) (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  video_mode_pkg::mode_code_t  sw,
	output video_mode_pkg::video_mode_t mode,
	output logic                        mode_change
);
	import video_mode_pkg::*;

	localparam int               CNT_W   = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_W-1:0] SETTLED = CNT_W'(DEBOUNCE_CYCLES - 1);

	mode_code_t       sw_meta;
	mode_code_t       sw_sync;
	mode_code_t       sw_q;       // Sampled code
	logic [CNT_W-1:0] stable_cnt;
	logic [2:0]       pwrup_cnt;
	video_mode_t      sw_mode;
	logic             settled;

	////////////////////////////////////////////////////////////////////////////
	// Switch sampling
	////////////////////////////////////////////////////////////////////////////

	// Two flops against metastability, then one register stage
	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
		sw_q    <= sw_sync;
	end

	assign sw_mode = decode_mode(sw_q);
	assign settled = (stable_cnt == SETTLED);

	// Cycles the sampled code has held still
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			stable_cnt <= '0;
		end else if (sw_sync != sw_q) begin
			stable_cnt <= '0;                         // Code about to move
		end else if (!settled) begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Mode change pulse
	////////////////////////////////////////////////////////////////////////////

	// Power-up change on the 4th edge after reset, mode stays at 720p for it
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			pwrup_cnt   <= 3'd0;
			mode        <= MODE_HD720;
			mode_change <= 1'b0;
		end else begin
			mode_change <= 1'b0;
			if (!pwrup_cnt[2]) begin
				pwrup_cnt   <= pwrup_cnt + 3'd1;
				mode_change <= (pwrup_cnt == 3'd3);
			end else if (settled && (sw_mode != mode)) begin
				mode        <= sw_mode;               // Same edge as the pulse
				mode_change <= 1'b1;
			end
		end
	end

endmodule

// ==== design/pclk_programmer.sv ====
`timescale 1ns/10ps

module pclk_programmer (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  video_mode_pkg::video_mode_t mode,
	input  logic                        mode_change,
	input  logic                        progdone,  // Synthesizer ready
	output logic                        progen,
	output logic                        progdata,
	output logic                        busy
);
	import clock_prog_pkg::*;

	prog_state_t state;
	synth_pair_t md_lut;
	synth_val_t  m_val;    // M-1 for the current request
	synth_val_t  d_val;    // D-1
	logic [9:0]  frame_d;
	logic [9:0]  frame_m;
	logic [8:0]  shreg;    // Bits still to go after the one on progdata
	logic [3:0]  bit_cnt;

	assign md_lut = clock_lookup(mode);

	// Header in the low bits so it leaves first, value LSB first after it
	assign frame_d = {d_val, LOAD_D};
	assign frame_m = {m_val, LOAD_M};

	// Mode is already the new one when the pulse arrives
	always_ff @(posedge clk50m_bufg) begin
		if (mode_change) begin
			m_val <= md_lut.m - 8'd1;
			d_val <= md_lut.d - 8'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			state    <= PS_IDLE;
			progen   <= 1'b0;
			progdata <= 1'b0;
			busy     <= 1'b0;
			bit_cnt  <= 4'd0;
		end else if (mode_change) begin
			// Restart from any state, progen drops for one cycle first
			state    <= PS_START;
			progen   <= 1'b0;
			progdata <= 1'b0;
			busy     <= 1'b1;
			bit_cnt  <= 4'd0;
		end else begin
			case (state)
				PS_START: begin
					state    <= PS_LOAD_D;
					progen   <= 1'b1;
					progdata <= frame_d[0];
					shreg    <= frame_d[9:1];
					bit_cnt  <= 4'd0;
				end
				PS_LOAD_D, PS_LOAD_M: begin
					if (bit_cnt == 4'd9) begin                 // 10th bit on the wire
						progen   <= 1'b0;
						progdata <= 1'b0;
						state    <= (state == PS_LOAD_D) ? PS_GAP_D : PS_GAP_M;
					end else begin
						progdata <= shreg[0];
						shreg    <= {1'b0, shreg[8:1]};
						bit_cnt  <= bit_cnt + 4'd1;
					end
				end
				PS_GAP_D: begin
					state    <= PS_LOAD_M;
					progen   <= 1'b1;
					progdata <= frame_m[0];
					shreg    <= frame_m[9:1];
					bit_cnt  <= 4'd0;
				end
				PS_GAP_M: begin
					state    <= PS_GO;
					progen   <= 1'b1;                          // GO is a single cycle, data 0
					progdata <= 1'b0;
				end
				PS_GO: begin
					state  <= PS_WAIT;
					progen <= 1'b0;
				end
				PS_WAIT: begin
					if (progdone) begin
						state <= PS_IDLE;
						busy  <= 1'b0;
					end
				end
				default: state <= PS_IDLE;
			endcase
		end
	end

endmodule

// ==== design/video_mode_pkg.sv ====
package video_mode_pkg;

	// Raw code from the four mode switches
	typedef logic [3:0] mode_code_t;

	// Pixel or line position
	typedef logic [10:0] tcount_t;

	typedef enum logic [2:0] {
		MODE_VGA,
		MODE_SVGA,
		MODE_XGA,
		MODE_HD720,
		MODE_SXGA,
		MODE_CAMERA
	} video_mode_t;

	// Terminal counts, position 0 is the first live pixel or line
	typedef struct packed {
		tcount_t hsblnk; // Last live pixel
		tcount_t hssync; // Sync goes active after this count
		tcount_t hesync; // Last count with sync active
		tcount_t heblnk; // Last count of the line
		tcount_t vsblnk;
		tcount_t vssync;
		tcount_t vesync;
		tcount_t veblnk;
	} timing_set_t;

	function automatic video_mode_t decode_mode(mode_code_t code);
		case (code)
			4'b0000: return MODE_VGA;
			4'b0001: return MODE_SVGA;
			4'b0011: return MODE_XGA;
			4'b1000: return MODE_SXGA;
			4'b1001: return MODE_CAMERA;
			default: return MODE_HD720; // 4'b0010 and every unused code
		endcase
	endfunction

	// Live, front porch, sync width, back porch for each direction
	function automatic timing_set_t make_set(int hpix, int hfp, int hsw, int hbp,
	                                         int vlin, int vfp, int vsw, int vbp);
		timing_set_t t;
		t.hsblnk = tcount_t'(hpix - 1);
		t.hssync = tcount_t'(hpix - 1 + hfp);
		t.hesync = tcount_t'(hpix - 1 + hfp + hsw);
		t.heblnk = tcount_t'(hpix - 1 + hfp + hsw + hbp);
		t.vsblnk = tcount_t'(vlin - 1);
		t.vssync = tcount_t'(vlin - 1 + vfp);
		t.vesync = tcount_t'(vlin - 1 + vfp + vsw);
		t.veblnk = tcount_t'(vlin - 1 + vfp + vsw + vbp);
		return t;
	endfunction

	function automatic timing_set_t timing_lookup(video_mode_t mode);
		case (mode)
			MODE_VGA:    return make_set(640,  16,  96,  48,  480,  11, 2, 31);
			MODE_SVGA:   return make_set(800,  40,  128, 88,  600,  1,  4, 23);
			MODE_XGA:    return make_set(1024, 24,  136, 160, 768,  3,  6, 29);
			MODE_SXGA:   return make_set(1280, 48,  112, 248, 1024, 1,  3, 38);
			MODE_CAMERA: return make_set(1280, 110, 39,  220, 720,  4,  4, 22);
			default:     return make_set(1280, 110, 40,  220, 720,  5,  5, 20); // 720p
		endcase
	endfunction

	// 1 = negative going syncs
	function automatic logic mode_polarity(video_mode_t mode);
		return (mode == MODE_VGA) || (mode == MODE_XGA);
	endfunction

endpackage

// ==== design/video_timing.sv ====
`timescale 1ns/10ps

module video_timing (
	input  logic                        clk50m_bufg,
	input  logic                        RSTBTN,
	input  video_mode_pkg::video_mode_t mode,
	input  logic                        mode_change,
	output video_mode_pkg::tcount_t     hcount,
	output video_mode_pkg::tcount_t     vcount,
	output logic                        hsync,
	output logic                        vsync,
	output logic                        de
);
	import video_mode_pkg::*;

	timing_set_t tset;
	logic        polarity;  // 1 = negative
	logic        h_end;
	logic        v_end;
	logic        hblnk;
	logic        vblnk;
	logic        hsync_raw;
	logic        vsync_raw;
	logic        active;
	logic        hsync_q;
	logic        vsync_q;
	logic        de_q;

	// Table for the running mode
	assign tset     = timing_lookup(mode);
	assign polarity = mode_polarity(mode);

	assign h_end = (hcount == tset.heblnk);   // Last pixel of the line
	assign v_end = (vcount == tset.veblnk);   // Last line of the frame

	////////////////////////////////////////////////////////////////////////////
	// Position counters
	////////////////////////////////////////////////////////////////////////////

	// A mode change restarts the frame at the top left corner
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || mode_change) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_end) begin
			hcount <= '0;
			vcount <= v_end ? '0 : vcount + 11'd1;  // Line step at end of line
		end else begin
			hcount <= hcount + 11'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Blanking and syncs
	////////////////////////////////////////////////////////////////////////////

	assign hblnk = (hcount > tset.hsblnk);
	assign vblnk = (vcount > tset.vsblnk);

	// Active high here, polarity fixed in the first register stage
	assign hsync_raw = (hcount > tset.hssync) && (hcount <= tset.hesync);
	assign vsync_raw = (vcount > tset.vssync) && (vcount <= tset.vesync);

	assign active = !hblnk && !vblnk;

	// Two register stages, outputs trail the counters by 2 cycles
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q <= mode_polarity(MODE_HD720);   // Inactive level of the default mode
			vsync_q <= mode_polarity(MODE_HD720);
			de_q    <= 1'b0;
			hsync   <= mode_polarity(MODE_HD720);
			vsync   <= mode_polarity(MODE_HD720);
			de      <= 1'b0;
		end else begin
			hsync_q <= hsync_raw ^ polarity;
			vsync_q <= vsync_raw ^ polarity;
			de_q    <= active;
			hsync   <= hsync_q;
			vsync   <= vsync_q;
			de      <= de_q;
		end
	end

endmodule

// ==== list.f ====
design/video_mode_pkg.sv
design/clock_prog_pkg.sv
design/mode_select.sv
design/pclk_programmer.sv
design/video_timing.sv
design/display_mode_top.sv
test/display_mode_assertions.sv
test/tb_display_mode.sv

// ==== test/display_mode_assertions.sv ====
`timescale 1ns/10ps

module display_mode_assertions (
	input logic clk50m_bufg,
	input logic RSTBTN,
	input logic progen,
	input logic busy,
	input logic hsync,
	input logic de,
	input logic hsync_idle   // Inactive hsync level of the running mode
);
	logic [4:0] en_run;      // Consecutive progen cycles already seen
	logic       idle_q1;
	logic       idle_q2;     // Idle level lined up with the 2 cycle output lag

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || !progen) begin
			en_run <= '0;
		end else if (en_run != 5'd31) begin
			en_run <= en_run + 5'd1;   // Saturates
		end
	end

	// Same two stages as the sync path
	always_ff @(posedge clk50m_bufg) begin
		idle_q1 <= hsync_idle;
		idle_q2 <= idle_q1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Serial port
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge clk50m_bufg) disable iff (RSTBTN) progen |-> en_run < 5'd10)
		else $error("progen held high longer than a 10 bit command");

	assert property (@(posedge clk50m_bufg) disable iff (RSTBTN) progen |-> busy)
		else $error("progen high while busy is low");

	// Live pixels never overlap the horizontal sync pulse
	assert property (@(posedge clk50m_bufg) disable iff (RSTBTN) de |-> (hsync == idle_q2))
		else $error("de high while hsync is active");

endmodule

// Programmer side, sync inputs tied to their idle values
bind pclk_programmer display_mode_assertions i_prog_assertions (
	.clk50m_bufg (clk50m_bufg),
	.RSTBTN      (RSTBTN),
	.progen      (progen),
	.busy        (busy),
	.hsync       (1'b0),
	.de          (1'b0),
	.hsync_idle  (1'b0)
);

bind video_timing display_mode_assertions i_timing_assertions (
	.clk50m_bufg (clk50m_bufg),
	.RSTBTN      (RSTBTN),
	.progen      (1'b0),
	.busy        (1'b0),
	.hsync       (hsync),
	.de          (de),
	.hsync_idle  (polarity)
);

// ==== test/tb_display_mode.sv ====
`timescale 1ns/10ps

module tb_display_mode;
	import video_mode_pkg::*;
	import clock_prog_pkg::*;

	localparam int DEBOUNCE  = 64;
	localparam int N_CHANGES = 6;     // Random settled codes after power-up
	// Each change: worst frame plus debounce, in ns, plus a margin
	localparam longint WATCHDOG_NS =
		longint'(N_CHANGES + 1) * longint'(2200 * 1125 + 4 * DEBOUNCE) * 20 + 40000;

	// Reference tables, indexed by mode: VGA SVGA XGA 720p SXGA camera
	localparam int HPIX [6] = '{640, 800, 1024, 1280, 1280, 1280};
	localparam int HFP  [6] = '{16, 40, 24, 110, 48, 110};
	localparam int HSW  [6] = '{96, 128, 136, 40, 112, 39};
	localparam int HBP  [6] = '{48, 88, 160, 220, 248, 220};
	localparam int VLIN [6] = '{480, 600, 768, 720, 1024, 720};
	localparam int VFP  [6] = '{11, 1, 3, 5, 1, 4};
	localparam int VSW  [6] = '{2, 4, 6, 5, 3, 4};
	localparam int VBP  [6] = '{31, 23, 29, 20, 38, 22};
	localparam int POL  [6] = '{1, 0, 1, 0, 0, 0};       // 1 = negative syncs
	localparam int MVAL [6] = '{2, 4, 13, 248, 54, 135};
	localparam int DVAL [6] = '{4, 5, 10, 167, 25, 91};

	logic        clk50m_bufg;
	logic        RSTBTN;
	mode_code_t  sw;
	logic        progdone;
	logic        progen;
	logic        progdata;
	logic        busy;
	logic        hsync;
	logic        vsync;
	logic        de;
	tcount_t     hcount;
	tcount_t     vcount;

	integer      seed;
	int          err_val;     // Wrong values
	int          err_proto;   // Missing frames, timeouts
	mode_code_t  code;
	video_mode_t cur;

	display_mode_top #(
		.DEBOUNCE_CYCLES (DEBOUNCE)
	) i_dut (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.progdone    (progdone),
		.progen      (progen),
		.progdata    (progdata),
		.busy        (busy),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.hcount      (hcount),
		.vcount      (vcount)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg;   // 50 MHz
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks and model helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_val(input synth_val_t got, input synth_val_t exp, input string what);
		if (got !== exp) begin
			err_val++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_count(input tcount_t got, input tcount_t exp, input string what);
		if (got !== exp) begin
			err_val++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			err_val++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Switch code to mode, unused codes fall back to 720p
	function automatic video_mode_t expected_mode(input mode_code_t c);
		case (c)
			4'b0000: return MODE_VGA;
			4'b0001: return MODE_SVGA;
			4'b0011: return MODE_XGA;
			4'b1000: return MODE_SXGA;
			4'b1001: return MODE_CAMERA;
			default: return MODE_HD720;
		endcase
	endfunction

	// Any of the 16 codes, as long as it lands on another mode
	task automatic pick_code(input video_mode_t avoid, output mode_code_t c);
		c = mode_code_t'($random(seed));
		while (expected_mode(c) == avoid) begin
			c = mode_code_t'($random(seed));
		end
	endtask

	task automatic report_counts();
		$display("Error counts: %0d wrong values, %0d protocol failures", err_val, err_proto);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Serial frames and progdone model
	////////////////////////////////////////////////////////////////////////////

	// Expects progen high on the very next cycle, one idle cycle before it
	task automatic read_frame(output logic [15:0] bits, output int len);
		bits = '0;
		len  = 0;
		@(negedge clk50m_bufg);
		if (!progen) begin
			err_proto++;
			$display("Error: no command frame after the one cycle gap at %0t", $time);
		end
		while (progen && len < 16) begin
			bits[len] = progdata;   // LSB first
			len++;
			@(negedge clk50m_bufg);
		end
	endtask

	task automatic verify_frames(input video_mode_t m);
		logic [15:0] bits;
		int          len;
		int          delay;
		compare_level(progen, 1'b0, "progen in the start gap");
		read_frame(bits, len);
		compare_count(tcount_t'(len), 11'd10, "LOAD_D frame length");
		compare_level(bits[0], 1'b1, "LOAD_D header bit 0");
		compare_level(bits[1], 1'b0, "LOAD_D header bit 1");
		compare_val(synth_val_t'(bits[9:2]), synth_val_t'(DVAL[int'(m)] - 1), "D-1");
		read_frame(bits, len);
		compare_count(tcount_t'(len), 11'd10, "LOAD_M frame length");
		compare_level(bits[0], 1'b1, "LOAD_M header bit 0");
		compare_level(bits[1], 1'b1, "LOAD_M header bit 1");
		compare_val(synth_val_t'(bits[9:2]), synth_val_t'(MVAL[int'(m)] - 1), "M-1");
		read_frame(bits, len);
		compare_count(tcount_t'(len), 11'd1, "GO length");
		compare_level(bits[0], 1'b0, "GO data");
		// Synthesizer lock time
		delay = 1 + ($unsigned($random(seed)) % 20);
		repeat (delay) @(posedge clk50m_bufg);
		progdone <= 1'b1;
		@(negedge clk50m_bufg);
		compare_level(busy, 1'b1, "busy before progdone is seen");
		@(posedge clk50m_bufg);
		progdone <= 1'b0;
		@(negedge clk50m_bufg);
		compare_level(busy, 1'b0, "busy after progdone");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Frame measurement
	////////////////////////////////////////////////////////////////////////////

	// Starts on the cycle the counters restart, runs one whole frame
	task automatic measure_frame(input video_mode_t m);
		int   idx;
		int   htot;
		int   vtot;
		int   h, v, h1, v1, h2, v2;   // Position now, 1 and 2 cycles back
		int   de_cnt, hs_cnt, de_lines, vs_lines, n;
		logic pol;
		logic de_exp;
		logic hs_exp;
		logic vs_exp;
		idx      = int'(m);
		htot     = HPIX[idx] + HFP[idx] + HSW[idx] + HBP[idx];
		vtot     = VLIN[idx] + VFP[idx] + VSW[idx] + VBP[idx];
		pol      = (POL[idx] != 0);
		h        = 0;
		v        = 0;
		h1       = 0;
		v1       = 0;
		h2       = 0;
		v2       = 0;
		de_cnt   = 0;
		hs_cnt   = 0;
		de_lines = 0;
		vs_lines = 0;
		for (n = 0; n < htot * vtot + 2; n++) begin
			if (n > 0) @(negedge clk50m_bufg);
			compare_count(hcount, tcount_t'(h), "hcount");
			compare_count(vcount, tcount_t'(v), "vcount");
			if (n >= 2) begin                         // Outputs describe h2/v2
				// Levels expected for the position two cycles back
				de_exp = (h2 < HPIX[idx]) && (v2 < VLIN[idx]);
				hs_exp = pol ^ ((h2 >= HPIX[idx] + HFP[idx]) &&
				                (h2 < HPIX[idx] + HFP[idx] + HSW[idx]));
				vs_exp = pol ^ ((v2 >= VLIN[idx] + VFP[idx]) &&
				                (v2 < VLIN[idx] + VFP[idx] + VSW[idx]));
				compare_level(de, de_exp, "de");
				compare_level(hsync, hs_exp, "hsync");
				compare_level(vsync, vs_exp, "vsync");
				de_cnt = de_cnt + int'(de);
				if (hsync != pol) hs_cnt++;
				if (h2 == 0 && vsync != pol) vs_lines++;
				if (h2 == htot - 1) begin
					compare_count(tcount_t'(de_cnt), tcount_t'(v2 < VLIN[idx] ? HPIX[idx] : 0),
					              "de pixels in line");
					compare_count(tcount_t'(hs_cnt), tcount_t'(HSW[idx]), "hsync width");
					if (de_cnt > 0) de_lines++;
					de_cnt = 0;
					hs_cnt = 0;
				end
			end
			h2 = h1;
			v2 = v1;
			h1 = h;
			v1 = v;
			if (h == htot - 1) begin
				h = 0;
				v = (v == vtot - 1) ? 0 : v + 1;
			end else begin
				h++;
			end
		end
		compare_count(tcount_t'(de_lines), tcount_t'(VLIN[idx]), "lines with de");
		compare_count(tcount_t'(vs_lines), tcount_t'(VSW[idx]), "vsync width in lines");
	endtask

	task automatic wait_busy_rise(input int limit, output logic ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < limit) begin
			@(negedge clk50m_bufg);
			ok = busy;
			n++;
		end
		if (!ok) begin
			err_proto++;
			$display("Error: no mode change seen within %0d cycles at %0t", limit, $time);
		end
	endtask

	task automatic run_change(input video_mode_t m);
		logic ok;
		wait_busy_rise(4 * DEBOUNCE + 32, ok);
		if (ok) begin
			fork
				verify_frames(m);
				measure_frame(m);
			join
		end
	endtask

	// Short excursion to another code, then back
	task automatic glitch_test(input mode_code_t keep, input video_mode_t m);
		mode_code_t g_code;
		int         g_len, htot, n;
		tcount_t    prev_h;
		pick_code(m, g_code);
		g_len  = 1 + ($unsigned($random(seed)) % (DEBOUNCE - 16));
		htot   = HPIX[int'(m)] + HFP[int'(m)] + HSW[int'(m)] + HBP[int'(m)];
		prev_h = hcount;
		for (n = 0; n < g_len + 4 * DEBOUNCE; n++) begin
			@(posedge clk50m_bufg);
			if (n == 0) sw <= g_code;
			if (n == g_len) sw <= keep;
			@(negedge clk50m_bufg);
			compare_level(busy, 1'b0, "busy after a glitch");
			compare_level(progen, 1'b0, "progen after a glitch");
			compare_count(hcount, (int'(prev_h) == htot - 1) ? 11'd0 : prev_h + 11'd1,
			              "hcount running through a glitch");
			prev_h = hcount;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed      = 24;
		err_val   = 0;
		err_proto = 0;
		RSTBTN   <= 1'b1;
		sw       <= 4'b0010;     // 720p, same as the power-up mode
		progdone <= 1'b0;
		repeat (9) @(posedge clk50m_bufg);
		@(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
		@(negedge clk50m_bufg);  // Still the reset state
		compare_level(progen, 1'b0, "progen after reset");
		compare_level(progdata, 1'b0, "progdata after reset");
		compare_level(busy, 1'b0, "busy after reset");
		compare_level(de, 1'b0, "de after reset");
		compare_level(hsync, 1'b0, "hsync after reset");
		compare_level(vsync, 1'b0, "vsync after reset");
		compare_count(hcount, 11'd0, "hcount after reset");
		compare_count(vcount, 11'd0, "vcount after reset");
		cur = MODE_HD720;
		run_change(cur);                           // Power-up change
		for (int k = 0; k < N_CHANGES; k++) begin
			pick_code(cur, code);
			@(posedge clk50m_bufg);
			sw <= code;
			cur = expected_mode(code);
			$display("Change %0d: code %b, mode %s", k, code, cur.name());
			run_change(cur);
			glitch_test(code, cur);
		end
		report_counts();
		if (err_val + err_proto == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Error: watchdog expired, the run took longer than its time limit");
		report_counts();
		$display("FAIL: see errors above");
		$finish;
	end

endmodule
